// File: Bender.yml
package:
  name: rv64_multicycle_core

sources:
  - files:
      - source/rv_pkg.sv
      - source/register_file.sv
      - source/alu.sv
      - source/extend_imm.sv
      - source/control_fsm.sv
      - source/datapath.sv
      - source/core_top.sv
  - target: test
    files:
      - tb/core_assertions.sv
      - tb/tb_core.sv

// File: source/alu.sv
// ALU for the integer operations of the core, with a zero flag for branch resolution.

`timescale 1ns/1ns

module alu
    import rv_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  alu_op_e         i_op,
    input  logic [XLEN-1:0] i_a,
    input  logic [XLEN-1:0] i_b,
    output logic [XLEN-1:0] o_result,
    output logic            o_zero
);

    logic lt_signed;
    logic lt_unsigned;

    // Comparisons for slt and sltu.
    assign lt_signed   = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;

    always_comb begin
        case (i_op)
            ALU_ADD:  o_result = i_a + i_b;
            ALU_SUB:  o_result = i_a - i_b;
            ALU_AND:  o_result = i_a & i_b;
            ALU_OR:   o_result = i_a | i_b;
            ALU_XOR:  o_result = i_a ^ i_b;
            ALU_SLT:  o_result = XLEN'(lt_signed);
            ALU_SLTU: o_result = XLEN'(lt_unsigned);
            default:  o_result = '0;
        endcase
    end

    // Set on an all-zero result.
    assign o_zero = (o_result == '0);

endmodule

// File: source/control_fsm.sv
// Control FSM that sequences fetch, decode, execute, memory and writeback one instruction at a time.

`timescale 1ns/1ns

module control_fsm
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    i_rst,
    input  status_t i_status,
    input  logic    i_mem_rd_done,
    input  logic    i_mem_wr_done,
    output ctrl_t   o_ctrl,
    output logic    o_mem_rd,
    output logic    o_mem_wr,
    output logic    o_halt
);

    state_e   state;
    state_e   state_next;
    imm_sel_e imm_fmt;
    alu_op_e  alu_func;
    logic     branch_taken;

    // ------------------------------
    // State and request strobes
    // ------------------------------

    // Request strobes are registered from the next state.
    // After reset the strobe is clear, so FETCH idles one cycle before issuing.
    always_ff @(posedge clk) begin
        if (i_rst) begin
            state    <= S_FETCH;
            o_mem_rd <= 1'b0;
            o_mem_wr <= 1'b0;
        end else begin
            state    <= state_next;
            o_mem_rd <= (state_next == S_FETCH) || (state_next == S_MEM_RD);
            o_mem_wr <= (state_next == S_MEM_WR);
        end
    end

    assign o_halt = (state == S_HALT);

    always_comb begin
        state_next = state;
        case (state)
            S_FETCH: begin
                if (o_mem_rd) begin
                    state_next = S_FETCH_WAIT;
                end
            end
            S_FETCH_WAIT: begin
                if (i_mem_rd_done) begin
                    state_next = S_DECODE;
                end
            end
            S_DECODE: begin
                case (i_status.op)
                    OPC_OP:                state_next = S_EXEC_R;
                    OPC_OP_IMM, OPC_LUI:   state_next = S_EXEC_I;
                    OPC_LOAD, OPC_STORE:   state_next = S_MEM_ADDR;
                    OPC_BRANCH:            state_next = S_BRANCH;
                    OPC_JAL:               state_next = S_JUMP;
                    default:               state_next = S_HALT;
                endcase
            end
            S_EXEC_R:      state_next = S_ALU_WB;
            // Lui uses EXEC_I as a spacer so its write lands with the ALU ops.
            S_EXEC_I:      state_next = (i_status.op == OPC_LUI) ? S_LUI_WB : S_ALU_WB;
            S_MEM_ADDR:    state_next = (i_status.op == OPC_LOAD) ? S_MEM_RD : S_MEM_WR;
            S_MEM_RD:      state_next = S_MEM_RD_WAIT;
            S_MEM_RD_WAIT: state_next = i_mem_rd_done ? S_MEM_WB : S_MEM_RD_WAIT;
            S_MEM_WR:      state_next = S_MEM_WR_WAIT;
            S_MEM_WR_WAIT: state_next = i_mem_wr_done ? S_FETCH : S_MEM_WR_WAIT;
            S_JUMP:        state_next = S_ALU_WB;
            S_HALT:        state_next = S_HALT;
            default:       state_next = S_FETCH;
        endcase
    end

    // ------------------------------
    // Instruction decode helpers
    // ------------------------------
    always_comb begin
        case (i_status.op)
            OPC_STORE:  imm_fmt = IMM_S;
            OPC_BRANCH: imm_fmt = IMM_B;
            OPC_JAL:    imm_fmt = IMM_J;
            OPC_LUI:    imm_fmt = IMM_U;
            default:    imm_fmt = IMM_I;
        endcase
    end

    always_comb begin
        case (i_status.funct3)
            3'b000:  alu_func = (i_status.op == OPC_OP && i_status.funct7_5) ? ALU_SUB : ALU_ADD;
            3'b010:  alu_func = ALU_SLT;
            3'b011:  alu_func = ALU_SLTU;
            3'b100:  alu_func = ALU_XOR;
            3'b110:  alu_func = ALU_OR;
            3'b111:  alu_func = ALU_AND;
            default: alu_func = ALU_ADD;
        endcase
    end

    // Beq and bne only.
    assign branch_taken = (i_status.funct3 == 3'b000) ? i_status.zero :
                          (i_status.funct3 == 3'b001) ? !i_status.zero : 1'b0;

    // ------------------------------
    // Control outputs per state
    // ------------------------------

    // Defaults hold rs1 + imm on the ALU, which keeps the data address stable.
    always_comb begin
        o_ctrl            = '0;
        o_ctrl.src_a      = SRC_A_RS1;
        o_ctrl.src_b      = SRC_B_IMM;
        o_ctrl.alu_op     = ALU_ADD;
        o_ctrl.imm_sel    = imm_fmt;
        o_ctrl.result_sel = RES_ALU_REG;
        case (state)
            S_FETCH_WAIT: begin
                o_ctrl.src_a      = SRC_A_PC;
                o_ctrl.src_b      = SRC_B_FOUR;
                o_ctrl.result_sel = RES_ALU;
                o_ctrl.instr_we   = i_mem_rd_done;
                o_ctrl.old_pc_we  = i_mem_rd_done;
                o_ctrl.pc_we      = i_mem_rd_done;
            end
            // Branch and jump target into the ALU result register.
            S_DECODE:      o_ctrl.src_a = SRC_A_OLD_PC;
            S_EXEC_R: begin
                o_ctrl.src_b  = SRC_B_RS2;
                o_ctrl.alu_op = alu_func;
            end
            S_EXEC_I:      o_ctrl.alu_op = alu_func;
            S_ALU_WB:      o_ctrl.reg_we = 1'b1;
            S_LUI_WB: begin
                o_ctrl.reg_we     = 1'b1;
                o_ctrl.result_sel = RES_IMM;
            end
            S_MEM_RD:      o_ctrl.addr_sel = 1'b1;
            S_MEM_RD_WAIT: begin
                o_ctrl.addr_sel = 1'b1;
                o_ctrl.mdr_we   = i_mem_rd_done;
            end
            S_MEM_WB: begin
                o_ctrl.reg_we     = 1'b1;
                o_ctrl.result_sel = RES_MDR;
            end
            S_MEM_WR, S_MEM_WR_WAIT: o_ctrl.addr_sel = 1'b1;
            S_BRANCH: begin
                o_ctrl.src_b  = SRC_B_RS2;
                o_ctrl.alu_op = ALU_SUB;
                o_ctrl.pc_we  = branch_taken;
            end
            // Target to PC while the ALU forms the link value.
            S_JUMP: begin
                o_ctrl.src_a = SRC_A_OLD_PC;
                o_ctrl.src_b = SRC_B_FOUR;
                o_ctrl.pc_we = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: source/core_top.sv
// Multicycle RV64I core top joining the control FSM and the datapath to one shared memory port.

`timescale 1ns/1ns

module core_top
    import rv_pkg::*;
#(
    parameter int              XLEN     = 64,
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            i_rst,
    input  logic [XLEN-1:0] i_mem_rdata,
    input  logic            i_mem_rd_done,
    input  logic            i_mem_wr_done,
    output logic [XLEN-1:0] o_mem_addr,
    output logic [XLEN-1:0] o_mem_wdata,
    output logic            o_mem_rd,
    output logic            o_mem_wr,
    output logic            o_halt
);

    ctrl_t   ctrl;
    status_t status;

    // ------------------------------
    // Control
    // ------------------------------
    control_fsm u_control_fsm (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_status      (status),
        .i_mem_rd_done (i_mem_rd_done),
        .i_mem_wr_done (i_mem_wr_done),
        .o_ctrl        (ctrl),
        .o_mem_rd      (o_mem_rd),
        .o_mem_wr      (o_mem_wr),
        .o_halt        (o_halt)
    );

    // ------------------------------
    // Datapath
    // ------------------------------
    datapath #(
        .XLEN     (XLEN),
        .RESET_PC (RESET_PC)
    ) u_datapath (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_ctrl        (ctrl),
        .i_mem_rdata   (i_mem_rdata),
        .i_mem_rd_done (i_mem_rd_done),
        .o_status      (status),
        .o_mem_addr    (o_mem_addr),
        .o_mem_wdata   (o_mem_wdata)
    );

endmodule

// File: source/datapath.sv
// Multicycle datapath with PC, instruction, operand and memory data registers and their muxes.

`timescale 1ns/1ns

module datapath
    import rv_pkg::*;
#(
    parameter int              XLEN     = 64,
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            i_rst,
    input  ctrl_t           i_ctrl,
    input  logic [XLEN-1:0] i_mem_rdata,
    input  logic            i_mem_rd_done,
    output status_t         o_status,
    output logic [XLEN-1:0] o_mem_addr,
    output logic [XLEN-1:0] o_mem_wdata
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] old_pc;
    logic [31:0]     instr;
    logic [XLEN-1:0] rs1_q;
    logic [XLEN-1:0] rs2_q;
    logic [XLEN-1:0] alu_q;
    logic [XLEN-1:0] mdr;
    logic [XLEN-1:0] rf_rdata_1;
    logic [XLEN-1:0] rf_rdata_2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] alu_out;
    logic            alu_zero;
    logic [XLEN-1:0] result;

    // ------------------------------
    // Architectural and holding registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc    <= RESET_PC;
            instr <= '0;
        end else begin
            if (i_ctrl.pc_we) begin
                pc <= result;
            end
            if (i_ctrl.instr_we) begin
                instr <= i_mem_rdata[31:0];
            end
        end
    end

    // Operands and ALU result load every cycle.
    always_ff @(posedge clk) begin
        if (i_ctrl.old_pc_we) begin
            old_pc <= pc;
        end
        if (i_ctrl.mdr_we && i_mem_rd_done) begin
            mdr <= i_mem_rdata;
        end
        rs1_q <= rf_rdata_1;
        rs2_q <= rf_rdata_2;
        alu_q <= alu_out;
    end

    // ------------------------------
    // Muxes
    // ------------------------------
    always_comb begin
        case (i_ctrl.src_a)
            SRC_A_PC:     src_a = pc;
            SRC_A_OLD_PC: src_a = old_pc;
            default:      src_a = rs1_q;
        endcase
        case (i_ctrl.src_b)
            SRC_B_RS2:  src_b = rs2_q;
            SRC_B_FOUR: src_b = XLEN'(4);
            default:    src_b = imm;
        endcase
        case (i_ctrl.result_sel)
            RES_ALU_REG: result = alu_q;
            RES_MDR:     result = mdr;
            RES_ALU:     result = alu_out;
            default:     result = imm;
        endcase
    end

    assign o_mem_addr  = i_ctrl.addr_sel ? alu_q : pc;
    assign o_mem_wdata = rs2_q;

    always_comb begin
        o_status.op       = opcode_e'(instr[6:0]);
        o_status.funct3   = instr[14:12];
        o_status.funct7_5 = instr[30];
        o_status.zero     = alu_zero;
    end

    // ------------------------------
    // Submodules
    // ------------------------------
    register_file #(.XLEN(XLEN)) u_register_file (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_we      (i_ctrl.reg_we),
        .i_addr_1  (instr[19:15]),
        .i_addr_2  (instr[24:20]),
        .i_addr_3  (instr[11:7]),
        .i_wdata   (result),
        .o_rdata_1 (rf_rdata_1),
        .o_rdata_2 (rf_rdata_2)
    );

    alu #(.XLEN(XLEN)) u_alu (
        .i_op     (i_ctrl.alu_op),
        .i_a      (src_a),
        .i_b      (src_b),
        .o_result (alu_out),
        .o_zero   (alu_zero)
    );

    extend_imm #(.XLEN(XLEN)) u_extend_imm (
        .i_sel   (i_ctrl.imm_sel),
        .i_instr (instr[31:7]),
        .o_imm   (imm)
    );

endmodule

// File: source/extend_imm.sv
// Immediate unit that assembles I, S, B, J and U immediates and sign-extends them to XLEN.

`timescale 1ns/1ns

module extend_imm
    import rv_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  imm_sel_e        i_sel,
    input  logic [31:7]     i_instr,
    output logic [XLEN-1:0] o_imm
);

    logic signed [31:0] imm32;

    // Each format is built at 32 bits first.
    always_comb begin
        case (i_sel)
            IMM_S:   imm32 = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            IMM_B:   imm32 = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                              i_instr[11:8], 1'b0};
            IMM_J:   imm32 = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                              i_instr[30:21], 1'b0};
            IMM_U:   imm32 = {i_instr[31:12], 12'b0};
            default: imm32 = {{20{i_instr[31]}}, i_instr[31:20]};
        endcase
    end

    // Sign extension up to XLEN.
    assign o_imm = XLEN'(imm32);

endmodule

// File: source/register_file.sv
// Register file with 32 XLEN-wide entries, two read ports, one write port and x0 fixed at zero.

`timescale 1ns/1ns

module register_file #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            i_rst,
    input  logic            i_we,
    input  logic [4:0]      i_addr_1,
    input  logic [4:0]      i_addr_2,
    input  logic [4:0]      i_addr_3,
    input  logic [XLEN-1:0] i_wdata,
    output logic [XLEN-1:0] o_rdata_1,
    output logic [XLEN-1:0] o_rdata_2
);

    logic [XLEN-1:0] regs [0:31];

    // Write port that never writes x0.
    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_addr_3 != 5'd0)) begin
            regs[i_addr_3] <= i_wdata;
        end
    end

    // Asynchronous reads.
    assign o_rdata_1 = (i_addr_1 == 5'd0) ? '0 : regs[i_addr_1];
    assign o_rdata_2 = (i_addr_2 == 5'd0) ? '0 : regs[i_addr_2];

endmodule

// File: source/rv_pkg.sv
// RV64I core package with opcodes, ALU operations, FSM states and control/status structs.

package rv_pkg;

    // ------------------------------
    // Instruction encodings
    // ------------------------------
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_LUI    = 7'b0110111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_J, IMM_U} imm_sel_e;

    // ------------------------------
    // Datapath mux selects
    // ------------------------------
    typedef enum logic [1:0] {SRC_A_PC, SRC_A_OLD_PC, SRC_A_RS1} src_a_e;
    typedef enum logic [1:0] {SRC_B_RS2, SRC_B_IMM, SRC_B_FOUR} src_b_e;
    typedef enum logic [1:0] {RES_ALU_REG, RES_MDR, RES_ALU, RES_IMM} result_e;

    typedef enum logic [3:0] {
        S_FETCH, S_FETCH_WAIT, S_DECODE,
        S_EXEC_R, S_EXEC_I, S_ALU_WB,
        S_MEM_ADDR, S_MEM_RD, S_MEM_RD_WAIT, S_MEM_WB, S_MEM_WR, S_MEM_WR_WAIT,
        S_BRANCH, S_JUMP, S_LUI_WB,
        S_HALT
    } state_e;

    // ------------------------------
    // Control and status bundles
    // ------------------------------
    typedef struct packed {
        logic      pc_we;
        logic      old_pc_we;
        logic      instr_we;
        logic      reg_we;
        logic      mdr_we;
        logic      addr_sel;    // 0 drives PC, 1 drives the ALU result register.
        src_a_e    src_a;
        src_b_e    src_b;
        alu_op_e   alu_op;
        imm_sel_e  imm_sel;
        result_e   result_sel;
    } ctrl_t;

    typedef struct packed {
        opcode_e    op;
        logic [2:0] funct3;
        logic       funct7_5;
        logic       zero;
    } status_t;

endpackage

// File: sources.f
source/rv_pkg.sv
source/register_file.sv
source/alu.sv
source/extend_imm.sv
source/control_fsm.sv
source/datapath.sv
source/core_top.sv
tb/core_assertions.sv
tb/tb_core.sv

// File: tb/core_assertions.sv
// Memory port protocol checker that is bound into core_top.

`timescale 1ns/1ns

module core_assertions #(
    parameter int              XLEN     = 64,
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input logic            clk,
    input logic            i_rst,
    input logic            i_mem_rd_done,
    input logic            i_mem_wr_done,
    input logic [XLEN-1:0] i_mem_addr,
    input logic [XLEN-1:0] i_mem_wdata,
    input logic            i_mem_rd,
    input logic            i_mem_wr,
    input logic            i_halt
);

    int   reset_fails = 0;
    int   protocol_fails = 0;
    int   halt_fails = 0;
    logic rst_q;
    logic pending_rd;
    logic pending_wr;
    logic seen_req;

    // ------------------------------
    // Outstanding request tracking
    // ------------------------------
    always_ff @(posedge clk) begin
        rst_q <= i_rst;
        if (i_rst) begin
            pending_rd <= 1'b0;
            pending_wr <= 1'b0;
            seen_req   <= 1'b0;
        end else begin
            if (i_mem_rd) begin
                pending_rd <= 1'b1;
            end else if (i_mem_rd_done) begin
                pending_rd <= 1'b0;
            end
            if (i_mem_wr) begin
                pending_wr <= 1'b1;
            end else if (i_mem_wr_done) begin
                pending_wr <= 1'b0;
            end
            if (i_mem_rd || i_mem_wr) begin
                seen_req <= 1'b1;
            end
        end
    end

    // ------------------------------
    // Properties
    // ------------------------------
    reset_quiet: assert property (@(posedge clk)
        (i_rst && rst_q) |-> (!i_mem_rd && !i_mem_wr && !i_halt)) else begin
        reset_fails++;
        $error("request or halt seen during reset");
    end

    first_fetch: assert property (@(posedge clk) disable iff (i_rst)
        (i_mem_rd && !seen_req) |-> (i_mem_addr == RESET_PC)) else begin
        reset_fails++;
        $error("first fetch address %h differs from reset PC", i_mem_addr);
    end

    single_pulse: assert property (@(posedge clk) disable iff (i_rst)
        (i_mem_rd || i_mem_wr) |=> !(i_mem_rd || i_mem_wr)) else begin
        protocol_fails++;
        $error("request strobe longer than one cycle");
    end

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (i_rst)
        !(i_mem_rd && i_mem_wr)) else begin
        protocol_fails++;
        $error("read and write strobes high together");
    end

    one_outstanding: assert property (@(posedge clk) disable iff (i_rst)
        (i_mem_rd || i_mem_wr) |-> !(pending_rd || pending_wr)) else begin
        protocol_fails++;
        $error("new request before the previous done pulse");
    end

    addr_stable: assert property (@(posedge clk) disable iff (i_rst)
        (pending_rd || pending_wr) |-> $stable(i_mem_addr)) else begin
        protocol_fails++;
        $error("address changed while a request was outstanding");
    end

    wdata_stable: assert property (@(posedge clk) disable iff (i_rst)
        pending_wr |-> $stable(i_mem_wdata)) else begin
        protocol_fails++;
        $error("write data changed while a write was outstanding");
    end

    halt_final: assert property (@(posedge clk) disable iff (i_rst)
        i_halt |-> (!i_mem_rd && !i_mem_wr) ##1 (i_halt && !i_mem_rd && !i_mem_wr)) else begin
        halt_fails++;
        $error("halt dropped or a request followed halt");
    end

endmodule

// File: tb/tb_core.sv
// Testbench for the multicycle core with a random-latency memory model and a fixed program.

`timescale 1ns/1ns

module tb_core
    import rv_pkg::*;
();

    localparam int              XLEN         = 64;
    localparam logic [XLEN-1:0] RESET_PC     = '0;
    localparam int              MEM_BYTES    = 4096;
    localparam int              HALT_TIMEOUT = 5000;
    localparam logic [63:0]     DATA_BASE    = 64'h400;
    localparam logic [63:0]     RES_BASE     = 64'h600;

    // Expected store tagged with the test it belongs to.
    typedef struct packed {
        logic [63:0] addr;
        logic [63:0] data;
        logic [2:0]  test;
    } store_t;

    logic            clk = 1'b0;
    logic            i_rst = 1'b1;
    logic [XLEN-1:0] i_mem_rdata = '0;
    logic            i_mem_rd_done = 1'b0;
    logic            i_mem_wr_done = 1'b0;
    logic [XLEN-1:0] o_mem_addr;
    logic [XLEN-1:0] o_mem_wdata;
    logic            o_mem_rd;
    logic            o_mem_wr;
    logic            o_halt;

    logic [7:0]      mem [0:MEM_BYTES-1];
    logic [31:0]     prog [$];
    store_t          expected [$];
    logic [63:0]     skip_pcs [$];
    logic [31:0]     lcg_state = 32'h7945;
    int              fails [6];
    string           test_names [6] = '{"reset", "protocol", "arithmetic",
                                        "x0 and lui", "control flow", "halt"};

    // Memory model request state.
    logic            busy = 1'b0;
    logic            req_write;
    logic [63:0]     req_addr;
    logic [63:0]     req_wdata;
    int              wait_left;

    always #10 clk = ~clk;

    core_top #(
        .XLEN     (XLEN),
        .RESET_PC (RESET_PC)
    ) DUT (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_mem_rdata   (i_mem_rdata),
        .i_mem_rd_done (i_mem_rd_done),
        .i_mem_wr_done (i_mem_wr_done),
        .o_mem_addr    (o_mem_addr),
        .o_mem_wdata   (o_mem_wdata),
        .o_mem_rd      (o_mem_rd),
        .o_mem_wr      (o_mem_wr),
        .o_halt        (o_halt)
    );

    bind core_top core_assertions #(
        .XLEN     (XLEN),
        .RESET_PC (RESET_PC)
    ) u_core_assertions (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_mem_rd_done (i_mem_rd_done),
        .i_mem_wr_done (i_mem_wr_done),
        .i_mem_addr    (o_mem_addr),
        .i_mem_wdata   (o_mem_wdata),
        .i_mem_rd      (o_mem_rd),
        .i_mem_wr      (o_mem_wr),
        .i_halt        (o_halt)
    );

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [63:0] load_word(input logic [63:0] addr);
        logic [63:0] word;
        for (int i = 0; i < 8; i++) begin
            word[8*i +: 8] = mem[(addr + i) % MEM_BYTES];
        end
        return word;
    endfunction

    task automatic store_word(input logic [63:0] addr, input logic [63:0] data);
        for (int i = 0; i < 8; i++) begin
            mem[(addr + i) % MEM_BYTES] = data[8*i +: 8];
        end
    endtask

    function automatic bit is_skipped(input logic [63:0] addr);
        foreach (skip_pcs[i]) begin
            if (skip_pcs[i] == addr) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Instruction encoders.
    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] encode_i(input opcode_e op, input logic [11:0] imm,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encode_s(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] encode_b(input logic [12:0] off, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] encode_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [63:0] next_pc();
        return RESET_PC + 64'(prog.size()) * 4;
    endfunction

    task automatic expect_store(input int slot, input logic [63:0] data, input int test);
        expected.push_back('{addr: RES_BASE + 64'(slot * 8), data: data, test: 3'(test)});
    endtask

    // Result goes to x5 and is stored to its own slot.
    task automatic r_case(input logic [6:0] f7, input logic [2:0] f3,
                          input logic [63:0] result, input int slot);
        prog.push_back(encode_r(f7, 5'd4, 5'd3, f3, 5'd5));
        prog.push_back(encode_s(12'(slot * 8), 5'd5, 5'd2));
        expect_store(slot, result, 2);
    endtask

    task automatic i_case(input logic [2:0] f3, input logic [11:0] imm,
                          input logic [63:0] result, input int slot);
        prog.push_back(encode_i(OPC_OP_IMM, imm, 5'd3, f3, 5'd5));
        prog.push_back(encode_s(12'(slot * 8), 5'd5, 5'd2));
        expect_store(slot, result, 2);
    endtask

    // ------------------------------
    // Program and expected stores
    // ------------------------------
    task automatic build_program();
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] sx [5];
        logic [11:0] imm [5];
        logic [19:0] uimm;
        logic [63:0] jal_pc;
        a = {next_random(), next_random()};
        b = {next_random(), next_random()};
        store_word(DATA_BASE, a);
        store_word(DATA_BASE + 8, b);
        for (int i = 0; i < 5; i++) begin
            imm[i] = 12'(next_random());
            sx[i]  = 64'($signed(imm[i]));
        end
        prog.push_back(encode_i(OPC_OP_IMM, 12'(DATA_BASE), 5'd0, 3'b000, 5'd1));
        prog.push_back(encode_i(OPC_OP_IMM, 12'(RES_BASE), 5'd0, 3'b000, 5'd2));
        prog.push_back(encode_i(OPC_LOAD, 12'd0, 5'd1, 3'b011, 5'd3));
        prog.push_back(encode_i(OPC_LOAD, 12'd8, 5'd1, 3'b011, 5'd4));
        r_case(7'h00, 3'b000, a + b, 0);
        r_case(7'h20, 3'b000, a - b, 1);
        r_case(7'h00, 3'b111, a & b, 2);
        r_case(7'h00, 3'b110, a | b, 3);
        r_case(7'h00, 3'b100, a ^ b, 4);
        r_case(7'h00, 3'b010, ($signed(a) < $signed(b)) ? 64'd1 : 64'd0, 5);
        r_case(7'h00, 3'b011, (a < b) ? 64'd1 : 64'd0, 6);
        i_case(3'b000, imm[0], a + sx[0], 7);
        i_case(3'b111, imm[1], a & sx[1], 8);
        i_case(3'b110, imm[2], a | sx[2], 9);
        i_case(3'b100, imm[3], a ^ sx[3], 10);
        i_case(3'b010, imm[4], ($signed(a) < $signed(sx[4])) ? 64'd1 : 64'd0, 11);
        // A write to x0 must be lost.
        prog.push_back(encode_i(OPC_OP_IMM, 12'd5, 5'd3, 3'b000, 5'd0));
        prog.push_back(encode_s(12'd96, 5'd0, 5'd2));
        expect_store(12, 64'd0, 3);
        uimm = 20'(next_random());
        prog.push_back({uimm, 5'd6, OPC_LUI});
        prog.push_back(encode_s(12'd104, 5'd6, 5'd2));
        expect_store(13, 64'($signed({uimm, 12'h000})), 3);
        // Taken beq over a marker.
        prog.push_back(encode_b(13'd8, 5'd3, 5'd3, 3'b000));
        skip_pcs.push_back(next_pc());
        prog.push_back(encode_s(12'd112, 5'd3, 5'd2));
        // Not-taken bne falls through.
        prog.push_back(encode_b(13'd8, 5'd3, 5'd3, 3'b001));
        prog.push_back(encode_s(12'd120, 5'd4, 5'd2));
        expect_store(15, b, 4);
        jal_pc = next_pc();
        prog.push_back(encode_j(21'd8, 5'd7));
        skip_pcs.push_back(next_pc());
        prog.push_back(encode_s(12'd128, 5'd3, 5'd2));
        prog.push_back(encode_s(12'd136, 5'd7, 5'd2));
        expect_store(17, jal_pc + 4, 4);
        prog.push_back(32'h0000_0073);
        foreach (prog[i]) begin
            for (int k = 0; k < 4; k++) begin
                mem[(RESET_PC + 4 * i + k) % MEM_BYTES] = prog[i][8*k +: 8];
            end
        end
    endtask

    task automatic check_store(input logic [63:0] addr, input logic [63:0] data);
        store_t exp;
        if (expected.size() == 0) begin
            $display("Store to address %h after the last expected store", addr);
            fails[4]++;
        end else begin
            exp = expected.pop_front();
            assert (addr == exp.addr) else begin
                $display("ERR o_mem_addr: expected %h got %h", exp.addr, addr);
                fails[exp.test]++;
            end
            assert (data == exp.data) else begin
                $display("ERR o_mem_wdata: expected %h got %h", exp.data, data);
                fails[exp.test]++;
            end
        end
    endtask

    // ------------------------------
    // Memory model
    // ------------------------------
    always @(negedge clk) begin
        i_mem_rd_done <= 1'b0;
        i_mem_wr_done <= 1'b0;
        if (i_rst) begin
            busy = 1'b0;
        end else if (o_mem_rd || o_mem_wr) begin
            busy      = 1'b1;
            req_write = o_mem_wr;
            req_addr  = o_mem_addr;
            req_wdata = o_mem_wdata;
            wait_left = 1 + int'(next_random() % 32'd8);
            if (o_mem_wr) begin
                check_store(o_mem_addr, o_mem_wdata);
            end else if (is_skipped(o_mem_addr)) begin
                $display("Fetch from skipped address %h", o_mem_addr);
                fails[4]++;
            end
        end else if (busy) begin
            wait_left--;
            if (wait_left == 0) begin
                busy = 1'b0;
                if (req_write) begin
                    store_word(req_addr, req_wdata);
                    i_mem_wr_done <= 1'b1;
                end else begin
                    i_mem_rdata   <= load_word(req_addr);
                    i_mem_rd_done <= 1'b1;
                end
            end
        end
    end

    // ------------------------------
    // Run and report
    // ------------------------------
    task automatic report_results();
        int passed;
        int failed;
        passed = 0;
        failed = 0;
        if (expected.size() != 0) begin
            $display("%0d expected stores never happened", expected.size());
            fails[expected[0].test]++;
        end
        assert (o_halt) else begin
            $display("ERR o_halt: expected %h got %h", 1'b1, o_halt);
            fails[5]++;
        end
        fails[0] += DUT.u_core_assertions.reset_fails;
        fails[1] += DUT.u_core_assertions.protocol_fails;
        fails[5] += DUT.u_core_assertions.halt_fails;
        for (int t = 0; t < 6; t++) begin
            $display("Test %-12s : %s", test_names[t], (fails[t] == 0) ? "PASS" : "FAIL");
            if (fails[t] == 0) begin
                passed++;
            end else begin
                failed++;
            end
        end
        $display("Tests run: %0d, passed: %0d, failed: %0d", passed + failed, passed, failed);
        if (failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    initial begin
        int cycles;
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem[a] = 8'(a) ^ 8'(a >> 8);
        end
        build_program();
        repeat (16) @(posedge clk);
        @(negedge clk);
        i_rst = 1'b0;
        for (cycles = 0; cycles < HALT_TIMEOUT && !o_halt; cycles++) begin
            @(negedge clk);
        end
        if (!o_halt) begin
            $display("Timeout: the core did not halt within %0d cycles", HALT_TIMEOUT);
            $display("Some tests failed");
            $finish;
        end else begin
            // Watch a quiet port after halt.
            repeat (20) @(negedge clk);
            report_results();
        end
    end

endmodule
